/* Makefile */
TOP = tb_csr_file

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

/* hw/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_NUM_W       14
`define CSR_DATA_W      32

// exception side
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033

// timer side
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044
`define CSR_CNT_LO      14'h060     // stable counter words
`define CSR_CNT_HI      14'h061

`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ESUBCODE_ADEF   9'h000      // fetch address error

`define ECFG_LIE_MASK   13'h1bff    // lie[10] reserved
`define TIMER_IDLE      32'hffff_ffff

`endif

/* hw/csr_except.sv */
`include "csr_cfg.svh"

module csr_except (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_wr_t      wr,
    input  csr_pkg::exc_req_t     exc,
    output csr_pkg::except_regs_t regs
);
    import csr_pkg::*;

    csr_word_u              crmd_m;     // crmd after the masked write
    logic [`CSR_DATA_W-1:0] prmd_m;
    logic [`CSR_DATA_W-1:0] ecfg_m;
    logic [1:0]             estat_is_m;
    logic [`CSR_DATA_W-1:0] era_m;
    logic [`CSR_DATA_W-1:0] eentry_m;
    logic [`CSR_DATA_W-1:0] badv_m;
    logic                   badv_hit;
    logic                   badv_pc;

    assign crmd_m.raw = csr_merge({23'b0, regs.crmd}, wr.wmask.raw, wr.wvalue.raw);
    assign prmd_m     = csr_merge({29'b0, regs.prmd_pie, regs.prmd_pplv},
                                  wr.wmask.raw, wr.wvalue.raw);
    assign ecfg_m     = csr_merge({19'b0, regs.ecfg_lie}, wr.wmask.raw, wr.wvalue.raw);
    assign era_m      = csr_merge(regs.era, wr.wmask.raw, wr.wvalue.raw);
    assign eentry_m   = csr_merge({regs.eentry_va, 6'b0}, wr.wmask.raw, wr.wvalue.raw);
    assign badv_m     = csr_merge(regs.badv, wr.wmask.raw, wr.wvalue.raw);

    // only is[1:0] of estat is software writable
    assign estat_is_m = (wr.wmask.estat.is[1:0] & wr.wvalue.estat.is[1:0])
                      | (~wr.wmask.estat.is[1:0] & regs.estat_is);

    // address errors record the faulting address
    assign badv_hit = (exc.ecode == `ECODE_ADE) || (exc.ecode == `ECODE_ALE);
    assign badv_pc  = (exc.ecode == `ECODE_ADE) && (exc.esubcode == `ESUBCODE_ADEF);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs         <= '0;
            regs.crmd.da <= 1'b1;   // direct translation out of reset
        end else begin
            // crmd, exception > ertn > write
            if (exc.ex) begin
                regs.crmd.plv <= 2'b0;
                regs.crmd.ie  <= 1'b0;
            end else if (exc.ertn) begin
                regs.crmd.plv <= regs.prmd_pplv;
                regs.crmd.ie  <= regs.prmd_pie;
            end else if (csr_hit(wr, `CSR_CRMD)) begin
                regs.crmd <= crmd_m.crmd.f;
            end

            // prmd keeps the mode of the interrupted code
            if (exc.ex) begin
                regs.prmd_pplv <= regs.crmd.plv;
                regs.prmd_pie  <= regs.crmd.ie;
            end else if (csr_hit(wr, `CSR_PRMD)) begin
                regs.prmd_pplv <= prmd_m[1:0];
                regs.prmd_pie  <= prmd_m[2];
            end

            if (csr_hit(wr, `CSR_ECFG)) begin
                regs.ecfg_lie <= ecfg_m[12:0] & `ECFG_LIE_MASK;
            end

            if (exc.ex) begin
                regs.estat_ecode    <= exc.ecode;
                regs.estat_esubcode <= exc.esubcode;
            end
            if (csr_hit(wr, `CSR_ESTAT)) begin
                regs.estat_is <= estat_is_m;
            end

            if (exc.ex) begin
                regs.era <= exc.pc;     // return address
            end else if (csr_hit(wr, `CSR_ERA)) begin
                regs.era <= era_m;
            end

            if (exc.ex && badv_hit) begin
                regs.badv <= badv_pc ? exc.pc : exc.vaddr;
            end else if (csr_hit(wr, `CSR_BADV)) begin
                regs.badv <= badv_m;
            end

            if (csr_hit(wr, `CSR_EENTRY)) begin
                regs.eentry_va <= eentry_m[31:6];   // low bits read 0
            end

            for (int i = 0; i < 4; i++) begin
                if (csr_hit(wr, `CSR_NUM_W'(`CSR_SAVE0 + i))) begin
                    regs.save[i] <= csr_merge(regs.save[i], wr.wmask.raw, wr.wvalue.raw);
                end
            end
        end
    end

endmodule

/* hw/csr_file.sv */
`include "csr_cfg.svh"

module csr_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CSR_NUM_W-1:0]  csr_num,
    input  logic                   csr_we,
    input  logic [`CSR_DATA_W-1:0] csr_wmask,
    input  logic [`CSR_DATA_W-1:0] csr_wvalue,
    input  logic                   wb_ex,
    input  logic                   ertn_flush,
    input  logic [5:0]             wb_ecode,
    input  logic [8:0]             wb_esubcode,
    input  logic [`CSR_DATA_W-1:0] wb_pc,
    input  logic [`CSR_DATA_W-1:0] wb_vaddr,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    output logic                   has_int,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic [`CSR_DATA_W-1:0] ertn_pc,
    output logic [1:0]             crmd_plv,
    output logic                   crmd_da,
    output logic                   crmd_pg,
    output logic [1:0]             crmd_datf,
    output logic [1:0]             crmd_datm
);
    import csr_pkg::*;

    csr_wr_t      wr;
    exc_req_t     exc;
    except_regs_t exc_regs;
    timer_regs_t  tmr_regs;
    logic         timer_irq;

    assign wr.we         = csr_we;
    assign wr.num        = csr_num;
    assign wr.wmask.raw  = csr_wmask;
    assign wr.wvalue.raw = csr_wvalue;

    assign exc.ex       = wb_ex;
    assign exc.ertn     = ertn_flush;
    assign exc.ecode    = wb_ecode;
    assign exc.esubcode = wb_esubcode;
    assign exc.pc       = wb_pc;
    assign exc.vaddr    = wb_vaddr;

    csr_except u_except (.clk(clk), .rst(rst), .wr(wr), .exc(exc), .regs(exc_regs));

    csr_timer u_timer (.clk(clk), .rst(rst), .wr(wr), .regs(tmr_regs), .timer_irq(timer_irq));

    csr_read_int u_read_int (
        .num(csr_num), .exc_regs(exc_regs), .tmr_regs(tmr_regs),
        .timer_irq(timer_irq), .rvalue(csr_rvalue), .has_int(has_int)
    );

    // fetch redirect targets
    assign ex_entry  = {exc_regs.eentry_va, 6'b0};
    assign ertn_pc   = exc_regs.era;
    assign crmd_plv  = exc_regs.crmd.plv;
    assign crmd_da   = exc_regs.crmd.da;
    assign crmd_pg   = exc_regs.crmd.pg;
    assign crmd_datf = exc_regs.crmd.datf;
    assign crmd_datm = exc_regs.crmd.datm;

endmodule

/* hw/csr_pkg.sv */
`include "csr_cfg.svh"

package csr_pkg;

    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic [29:0] initval;   // counter start is initval * 4
        logic        periodic;
        logic        en;
    } tcfg_t;

    // one csr word seen through the layout of the addressed register
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        struct packed {
            logic [22:0] rsv;
            crmd_t       f;
        } crmd;
        tcfg_t tcfg;
        struct packed {
            logic        rsv1;
            logic [8:0]  esubcode;
            logic [5:0]  ecode;
            logic [2:0]  rsv0;
            logic [12:0] is;
        } estat;
    } csr_word_u;

    typedef struct packed {
        logic                  we;
        logic [`CSR_NUM_W-1:0] num;
        csr_word_u             wmask;
        csr_word_u             wvalue;
    } csr_wr_t;

    typedef struct packed {
        logic                   ex;     // exception from writeback
        logic                   ertn;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } exc_req_t;

    typedef struct packed {
        crmd_t                            crmd;
        logic [1:0]                       prmd_pplv;
        logic                             prmd_pie;
        logic [12:0]                      ecfg_lie;
        logic [1:0]                       estat_is;   // software interrupt bits
        logic [5:0]                       estat_ecode;
        logic [8:0]                       estat_esubcode;
        logic [`CSR_DATA_W-1:0]           era;
        logic [25:0]                      eentry_va;  // entry address [31:6]
        logic [`CSR_DATA_W-1:0]           badv;
        logic [3:0][`CSR_DATA_W-1:0]      save;
    } except_regs_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] tid;
        tcfg_t                  tcfg;
        logic [`CSR_DATA_W-1:0] tval;
        logic [63:0]            cnt;    // stable counter
    } timer_regs_t;

    function automatic logic csr_hit(input csr_wr_t w, input logic [`CSR_NUM_W-1:0] num);
        return w.we && (w.num == num);
    endfunction

    // masked bits take the new value, the rest keep the old one
    function automatic logic [`CSR_DATA_W-1:0] csr_merge(
        input logic [`CSR_DATA_W-1:0] old_v,
        input logic [`CSR_DATA_W-1:0] mask,
        input logic [`CSR_DATA_W-1:0] val
    );
        return (mask & val) | (~mask & old_v);
    endfunction

endpackage

/* hw/csr_read_int.sv */
`include "csr_cfg.svh"

module csr_read_int (
    input  logic [`CSR_NUM_W-1:0]  num,
    input  csr_pkg::except_regs_t  exc_regs,
    input  csr_pkg::timer_regs_t   tmr_regs,
    input  logic                   timer_irq,
    output logic [`CSR_DATA_W-1:0] rvalue,
    output logic                   has_int
);
    import csr_pkg::*;

    logic [12:0] is_all;    // full pending vector
    csr_word_u   crmd_rd;
    csr_word_u   estat_rd;

    // hardware and ipi lines are not wired here
    assign is_all = {1'b0, timer_irq, 9'b0, exc_regs.estat_is};

    always_comb begin
        crmd_rd                 = '0;
        crmd_rd.crmd.f          = exc_regs.crmd;
        estat_rd                = '0;
        estat_rd.estat.is       = is_all;
        estat_rd.estat.ecode    = exc_regs.estat_ecode;
        estat_rd.estat.esubcode = exc_regs.estat_esubcode;
    end

    always_comb begin
        case (num)
            `CSR_CRMD:   rvalue = crmd_rd.raw;
            `CSR_PRMD:   rvalue = {29'b0, exc_regs.prmd_pie, exc_regs.prmd_pplv};
            `CSR_ECFG:   rvalue = {19'b0, exc_regs.ecfg_lie};
            `CSR_ESTAT:  rvalue = estat_rd.raw;
            `CSR_ERA:    rvalue = exc_regs.era;
            `CSR_BADV:   rvalue = exc_regs.badv;
            `CSR_EENTRY: rvalue = {exc_regs.eentry_va, 6'b0};
            `CSR_SAVE0:  rvalue = exc_regs.save[0];
            `CSR_SAVE1:  rvalue = exc_regs.save[1];
            `CSR_SAVE2:  rvalue = exc_regs.save[2];
            `CSR_SAVE3:  rvalue = exc_regs.save[3];
            `CSR_TID:    rvalue = tmr_regs.tid;
            `CSR_TCFG:   rvalue = tmr_regs.tcfg;
            `CSR_TVAL:   rvalue = tmr_regs.tval;
            `CSR_TICLR:  rvalue = '0;      // write only clear
            `CSR_CNT_LO: rvalue = tmr_regs.cnt[31:0];
            `CSR_CNT_HI: rvalue = tmr_regs.cnt[63:32];
            default:     rvalue = '0;
        endcase
    end

    // local enable per line, then the global ie
    assign has_int = (|(is_all[11:0] & exc_regs.ecfg_lie[11:0])) & exc_regs.crmd.ie;

endmodule

/* hw/csr_timer.sv */
`include "csr_cfg.svh"

module csr_timer (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_wr_t     wr,
    output csr_pkg::timer_regs_t regs,
    output logic                 timer_irq
);
    import csr_pkg::*;

    csr_word_u              tcfg_m;     // tcfg after this cycle's write
    logic [`CSR_DATA_W-1:0] tid_m;
    logic [`CSR_DATA_W-1:0] reload_val;
    logic                   tcfg_wr;
    logic                   tcfg_load;
    logic                   ticlr_clr;
    logic                   cnt_run;
    logic                   cnt_zero;

    assign tcfg_m.raw = csr_merge(regs.tcfg, wr.wmask.raw, wr.wvalue.raw);
    assign tid_m      = csr_merge(regs.tid, wr.wmask.raw, wr.wvalue.raw);
    assign reload_val = {regs.tcfg.initval, 2'b00};

    assign tcfg_wr   = csr_hit(wr, `CSR_TCFG);
    assign tcfg_load = tcfg_wr && tcfg_m.tcfg.en;   // new en decides the load
    assign ticlr_clr = csr_hit(wr, `CSR_TICLR) && wr.wmask.raw[0] && wr.wvalue.raw[0];

    // idle value parks the counter
    assign cnt_run  = regs.tcfg.en && (regs.tval != `TIMER_IDLE);
    assign cnt_zero = cnt_run && (regs.tval == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs.tid  <= '0;
            regs.tcfg <= '0;
            regs.tval <= `TIMER_IDLE;
            regs.cnt  <= '0;
            timer_irq <= 1'b0;
        end else begin
            regs.cnt <= regs.cnt + 64'd1;   // free running

            if (csr_hit(wr, `CSR_TID)) begin
                regs.tid <= tid_m;
            end
            if (tcfg_wr) begin
                regs.tcfg <= tcfg_m.tcfg;
            end

            if (tcfg_load) begin
                regs.tval <= {tcfg_m.tcfg.initval, 2'b00};
            end else if (cnt_zero) begin
                // one shot falls to idle and stops
                regs.tval <= regs.tcfg.periodic ? reload_val : `TIMER_IDLE;
            end else if (cnt_run) begin
                regs.tval <= regs.tval - 32'd1;
            end

            // a set in the same cycle beats the clear
            if (cnt_zero) begin
                timer_irq <= 1'b1;
            end else if (ticlr_clr) begin
                timer_irq <= 1'b0;
            end
        end
    end

endmodule

/* sim.f */
+incdir+hw
hw/csr_pkg.sv
hw/csr_except.sv
hw/csr_timer.sv
hw/csr_read_int.sv
hw/csr_file.sv
testbench/tb_csr_file.sv

/* testbench/tb_csr_file.sv */
`include "csr_cfg.svh"

module tb_csr_file;

    logic                   clk;
    logic                   rst;
    logic [`CSR_NUM_W-1:0]  csr_num;
    logic                   csr_we;
    logic [`CSR_DATA_W-1:0] csr_wmask;
    logic [`CSR_DATA_W-1:0] csr_wvalue;
    logic                   wb_ex;
    logic                   ertn_flush;
    logic [5:0]             wb_ecode;
    logic [8:0]             wb_esubcode;
    logic [`CSR_DATA_W-1:0] wb_pc;
    logic [`CSR_DATA_W-1:0] wb_vaddr;
    logic [`CSR_DATA_W-1:0] csr_rvalue;
    logic                   has_int;
    logic [`CSR_DATA_W-1:0] ex_entry;
    logic [`CSR_DATA_W-1:0] ertn_pc;
    logic [1:0]             crmd_plv;
    logic                   crmd_da;
    logic                   crmd_pg;
    logic [1:0]             crmd_datf;
    logic [1:0]             crmd_datm;

    int          err_count;
    int          tests_run;
    int          tests_failed;
    logic [5:0]  last_ecode;    // codes of the latest exception
    logic [8:0]  last_esub;
    logic [31:0] eentry_exp;    // entry address left by the masked writes

    csr_file uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic write_reg(input logic [`CSR_NUM_W-1:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        @(posedge clk);
        csr_we     <= 1'b1;
        csr_num    <= num;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        @(posedge clk);
        csr_we     <= 1'b0;
    endtask

    // read value is combinational, sampled mid cycle
    task automatic read_reg(input logic [`CSR_NUM_W-1:0] num, output logic [31:0] value);
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        value = csr_rvalue;
    endtask

    task automatic expect_reg(input string name, input logic [`CSR_NUM_W-1:0] num,
                              input logic [31:0] exp);
        logic [31:0] value;
        read_reg(num, value);
        check_eq(name, exp, value);
    endtask

    task automatic expect_int(input string name, input logic exp);
        @(negedge clk);
        check_eq(name, exp, has_int);
    endtask

    task automatic wait_int(input string name, input logic level, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (has_int !== level && n < limit);
        if (has_int !== level) begin
            $display("%s: has_int did not reach %0b within %0d cycles", name, level, limit);
            err_count++;
        end
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= ecode;
        wb_esubcode <= esub;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        @(posedge clk);
        wb_ex       <= 1'b0;
        last_ecode = ecode;
        last_esub  = esub;
    endtask

    task automatic return_from_exception();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    // estat layout: is[12:0], ecode[21:16], esubcode[30:22]
    function automatic logic [31:0] estat_word(input logic [5:0] ecode, input logic [8:0] esub,
                                               input logic [12:0] is);
        return {1'b0, esub, ecode, 3'b000, is};
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic reset_state();
        int e;
        e = err_count;
        expect_reg("reset crmd", `CSR_CRMD, 32'h8);     // da only
        expect_reg("reset prmd", `CSR_PRMD, 32'h0);
        expect_reg("reset estat", `CSR_ESTAT, 32'h0);
        expect_reg("reset era", `CSR_ERA, 32'h0);
        expect_reg("reset tval", `CSR_TVAL, 32'hffff_ffff);
        check_eq("reset has_int", 1'b0, has_int);
        check_eq("reset crmd_da", 1'b1, crmd_da);
        check_eq("reset ex_entry", 32'h0, ex_entry);
        check_eq("reset ertn_pc", 32'h0, ertn_pc);
        check_eq("reset crmd_plv", 2'd0, crmd_plv);
        check_eq("reset crmd_pg", 1'b0, crmd_pg);
        check_eq("reset crmd_datf", 2'd0, crmd_datf);
        check_eq("reset crmd_datm", 2'd0, crmd_datm);
        finish_test("reset_state", e);
    endtask

    task automatic masked_writes();
        logic [`CSR_NUM_W-1:0] nums [6];
        logic [31:0]           model [6];
        logic [31:0]           mask;
        logic [31:0]           value;
        int                    e;
        e = err_count;
        nums = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_ERA, `CSR_EENTRY};
        for (int i = 0; i < 6; i++) begin
            model[i] = 32'h0;
        end
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 6; i++) begin
                mask     = $urandom;
                value    = $urandom;
                model[i] = (value & mask) | (model[i] & ~mask);
                if (nums[i] == `CSR_EENTRY) begin
                    model[i][5:0] = 6'b0;   // entry is 64 byte aligned
                end
                write_reg(nums[i], mask, value);
                expect_reg($sformatf("masked write %h", nums[i]), nums[i], model[i]);
            end
        end
        eentry_exp = model[5];
        write_reg(`CSR_ECFG, 32'hffff_ffff, 32'hffff_ffff);
        expect_reg("ecfg all ones", `CSR_ECFG, 32'h1bff);
        write_reg(`CSR_ECFG, 32'hffff_ffff, 32'h0);
        expect_reg("unused number", 14'h3ff, 32'h0);
        finish_test("masked_writes", e);
    endtask

    task automatic exception_return();
        logic [31:0] pc;
        int          e;
        e  = err_count;
        pc = $urandom & ~32'h3;
        write_reg(`CSR_CRMD, 32'h7, 32'h7);     // plv 3, ie 1
        raise_exception(`ECODE_ADE, `ESUBCODE_ADEF, pc, 32'h1234_5678);
        expect_reg("ex crmd", `CSR_CRMD, 32'h8);
        check_eq("ex crmd_plv", 2'd0, crmd_plv);
        expect_reg("ex prmd", `CSR_PRMD, 32'h7);
        expect_reg("ex era", `CSR_ERA, pc);
        check_eq("ex ertn_pc", pc, ertn_pc);
        check_eq("ex ex_entry", eentry_exp, ex_entry);
        expect_reg("ex estat", `CSR_ESTAT, estat_word(`ECODE_ADE, `ESUBCODE_ADEF, 13'h0));
        expect_reg("ex badv adef", `CSR_BADV, pc);
        return_from_exception();
        expect_reg("ertn crmd", `CSR_CRMD, 32'hf);
        check_eq("ertn crmd_plv", 2'd3, crmd_plv);
        // data side faults take vaddr
        raise_exception(`ECODE_ALE, 9'h0, pc + 32'd4, 32'hdead_beef);
        expect_reg("ex badv ale", `CSR_BADV, 32'hdead_beef);
        raise_exception(`ECODE_ADE, 9'h1, pc + 32'd8, 32'h0bad_0010);
        expect_reg("ex badv adem", `CSR_BADV, 32'h0bad_0010);
        raise_exception(6'h0b, 9'h0, pc + 32'd12, 32'h5555_0000);
        expect_reg("ex badv kept", `CSR_BADV, 32'h0bad_0010);
        expect_reg("ex estat syscall", `CSR_ESTAT, estat_word(6'h0b, 9'h0, 13'h0));
        // translation and access type fields
        write_reg(`CSR_CRMD, 32'h1f8, 32'h130);     // da 0, pg 1, datf 1, datm 2
        expect_reg("crmd fields", `CSR_CRMD, 32'h130);
        check_eq("crmd_da", 1'b0, crmd_da);
        check_eq("crmd_pg", 1'b1, crmd_pg);
        check_eq("crmd_datf", 2'd1, crmd_datf);
        check_eq("crmd_datm", 2'd2, crmd_datm);
        finish_test("exception_return", e);
    endtask

    task automatic oneshot_timer();
        int e;
        e = err_count;
        write_reg(`CSR_ECFG, 32'hffff_ffff, 32'h800);   // timer line only
        write_reg(`CSR_CRMD, 32'h4, 32'h4);
        write_reg(`CSR_TCFG, 32'hffff_ffff, {30'd3, 1'b0, 1'b1});
        wait_int("oneshot_timer", 1'b1, 40);
        expect_reg("oneshot tval idle", `CSR_TVAL, 32'hffff_ffff);
        repeat (8) @(posedge clk);
        expect_reg("oneshot tval stays", `CSR_TVAL, 32'hffff_ffff);
        check_eq("oneshot has_int held", 1'b1, has_int);
        expect_reg("oneshot estat", `CSR_ESTAT, estat_word(last_ecode, last_esub, 13'h800));
        write_reg(`CSR_TICLR, 32'h1, 32'h1);
        expect_int("oneshot cleared", 1'b0);
        repeat (20) @(posedge clk);
        expect_int("oneshot no repeat", 1'b0);
        finish_test("oneshot_timer", e);
    endtask

    task automatic periodic_timer();
        logic [31:0] lo_a;
        logic [31:0] lo_b;
        int          k;
        int          e;
        e = err_count;
        write_reg(`CSR_TCFG, 32'hffff_ffff, {30'd4, 1'b1, 1'b1});
        for (int p = 0; p < 3; p++) begin
            wait_int("periodic_timer", 1'b1, 18);   // period is 17 cycles
            write_reg(`CSR_TICLR, 32'h1, 32'h1);
            expect_int("periodic cleared", 1'b0);
        end
        write_reg(`CSR_TCFG, 32'hffff_ffff, 32'h0);
        write_reg(`CSR_TICLR, 32'h1, 32'h1);
        repeat (20) @(posedge clk);     // longer than one period
        expect_int("periodic stopped", 1'b0);

        k = 5 + ($urandom % 30);
        @(posedge clk);
        csr_num <= `CSR_CNT_LO;
        @(negedge clk);
        lo_a = csr_rvalue;
        repeat (k) @(negedge clk);
        lo_b = csr_rvalue;
        check_eq("stable counter step", k, lo_b - lo_a);
        expect_reg("stable counter hi", `CSR_CNT_HI, 32'h0);
        finish_test("periodic_timer", e);
    endtask

    task automatic software_interrupt();
        int e;
        e = err_count;
        write_reg(`CSR_ECFG, 32'hffff_ffff, 32'h1);
        write_reg(`CSR_CRMD, 32'h4, 32'h4);
        expect_int("swi idle", 1'b0);
        // is[0] plus the read only fields
        write_reg(`CSR_ESTAT, 32'hffff_ffff, 32'h7fff_e801);
        expect_int("swi raised", 1'b1);
        expect_reg("swi estat", `CSR_ESTAT, estat_word(last_ecode, last_esub, 13'h001));
        write_reg(`CSR_CRMD, 32'h4, 32'h0);
        expect_int("swi ie off", 1'b0);
        write_reg(`CSR_ESTAT, 32'h1, 32'h0);
        expect_reg("swi cleared", `CSR_ESTAT, estat_word(last_ecode, last_esub, 13'h0));
        finish_test("software_interrupt", e);
    endtask

    initial begin
        void'($urandom(2199));
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_ecode   = 6'h0;
        last_esub    = 9'h0;
        eentry_exp   = 32'h0;
        rst          = 1'b1;
        csr_num      = '0;
        csr_we       = 1'b0;
        csr_wmask    = '0;
        csr_wvalue   = '0;
        wb_ex        = 1'b0;
        ertn_flush   = 1'b0;
        wb_ecode     = '0;
        wb_esubcode  = '0;
        wb_pc        = '0;
        wb_vaddr     = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        reset_state();
        masked_writes();
        exception_return();
        oneshot_timer();
        periodic_timer();
        software_interrupt();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
